// File: common/rv32_pkg.sv
package rv32_pkg;

  typedef logic [31:0] word_t;     // Data, address or instruction word
  typedef logic [4:0]  reg_idx_t;  // Register number
  typedef logic [3:0]  byte_en_t;  // One enable per byte lane

  // Major opcodes, insn[6:0]
  localparam logic [6:0] op_lui      = 7'b0110111;
  localparam logic [6:0] op_auipc    = 7'b0010111;
  localparam logic [6:0] op_jal      = 7'b1101111;
  localparam logic [6:0] op_jalr     = 7'b1100111;
  localparam logic [6:0] op_branch   = 7'b1100011;
  localparam logic [6:0] op_load     = 7'b0000011;
  localparam logic [6:0] op_store    = 7'b0100011;
  localparam logic [6:0] op_reg_imm  = 7'b0010011;
  localparam logic [6:0] op_reg_reg  = 7'b0110011;
  localparam logic [6:0] op_system   = 7'b1110011;
  localparam logic [6:0] op_misc_mem = 7'b0001111;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b   // Operand b straight through, for LUI and store data
  } alu_op_e;

  typedef struct packed {
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [2:0] funct3;
    word_t      imm;        // Already sign-extended
    alu_op_e    alu_op;
    logic       use_imm;    // ALU operand b is imm, not rs2
    logic       reg_write;
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       is_auipc;
    logic       is_ecall;
  } decoded_t;

  typedef struct packed {
    word_t alu_result;
    word_t mem_addr;   // rs1 + imm, byte address
    word_t next_pc;    // Taken target or pc + 4
    word_t link_pc;    // pc + 4
  } exec_t;

  typedef struct packed {
    word_t    addr;     // Word-aligned
    word_t    wdata;    // Already placed in its byte lanes
    byte_en_t byte_en;
  } dmem_req_t;

endpackage

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
  parameter rv32_pkg::word_t reset_pc = '0
) (
  input  logic               clk,
  input  logic               rst,
  input  rv32_pkg::decoded_t dec,
  input  rv32_pkg::exec_t    exe,
  output rv32_pkg::word_t    pc,
  output logic               halt
);

  // The ECALL cycle still advances pc, after that both registers freeze
  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= reset_pc;
      halt <= 1'b0;
    end else if (!halt) begin
      pc   <= exe.next_pc;
      halt <= dec.is_ecall;  // Sticky, nothing clears it but rst
    end
  end

  // Taken targets are computed from imm and rs1, so a bad program would show up here
  pc_word_aligned: assert property (
    @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
  );

endmodule

// File: decode/insn_decoder.sv
`timescale 1ns/1ps

module insn_decoder (
  input  rv32_pkg::word_t    insn,
  output rv32_pkg::decoded_t dec
);
  import rv32_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_b5;  // Selects SUB and SRA/SRAI
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  function automatic alu_op_e alu_select(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? alu_sub : alu_add;
      3'b001:  op = alu_sll;
      3'b010:  op = alu_slt;
      3'b011:  op = alu_sltu;
      3'b100:  op = alu_xor;
      3'b101:  op = alt ? alu_sra : alu_srl;
      3'b110:  op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  assign opcode    = insn[6:0];
  assign funct3    = insn[14:12];
  assign funct7_b5 = insn[30];

  // Immediate forms
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    dec        = '0;
    dec.rd     = insn[11:7];
    dec.rs1    = insn[19:15];
    dec.rs2    = insn[24:20];
    dec.funct3 = funct3;
    dec.alu_op = alu_add;

    case (opcode)
      op_lui: begin
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        dec.alu_op    = alu_pass_b;
      end
      op_auipc: begin
        dec.imm       = imm_u;
        dec.reg_write = 1'b1;
        dec.is_auipc  = 1'b1;
      end
      op_jal: begin
        dec.imm       = imm_j;
        dec.reg_write = 1'b1;
        dec.is_jal    = 1'b1;
      end
      op_jalr: begin
        dec.imm       = imm_i;
        dec.reg_write = 1'b1;
        dec.is_jalr   = 1'b1;
      end
      op_branch: begin
        dec.imm       = imm_b;
        dec.is_branch = 1'b1;
      end
      op_load: begin
        dec.imm       = imm_i;
        dec.reg_write = 1'b1;
        dec.is_load   = 1'b1;
      end
      op_store: begin
        dec.imm      = imm_s;
        dec.is_store = 1'b1;
        dec.alu_op   = alu_pass_b;  // rs2 rides through the ALU as store data
      end
      op_reg_imm: begin
        dec.imm       = imm_i;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        // Bit 30 is an immediate bit except for the shift-right pair
        dec.alu_op    = alu_select(funct3, funct3 == 3'b101 && funct7_b5);
      end
      op_reg_reg: begin
        dec.reg_write = 1'b1;
        dec.alu_op    = alu_select(funct3, funct7_b5);
      end
      op_system:   dec.is_ecall = insn[31:7] == '0;  // EBREAK and CSRs fall through
      op_misc_mem: ;                                 // FENCE retires as a no-op
      default:     ;
    endcase
  end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic               clk,
  input  logic               rst,
  input  rv32_pkg::reg_idx_t rs1,
  input  rv32_pkg::reg_idx_t rs2,
  output rv32_pkg::word_t    rs1_data,
  output rv32_pkg::word_t    rs2_data,
  input  logic               we,
  input  rv32_pkg::reg_idx_t rd,
  input  rv32_pkg::word_t    wdata
);
  import rv32_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin  // x0 keeps its cleared value
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 storage is only ever loaded by reset
  x0_never_written: assert property (
    @(posedge clk) disable iff (rst) regs[0] == '0
  );

endmodule

// File: execute/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
  input  rv32_pkg::decoded_t dec,
  input  rv32_pkg::word_t    pc,
  input  rv32_pkg::word_t    rs1_data,
  input  rv32_pkg::word_t    rs2_data,
  output rv32_pkg::exec_t    exe
);
  import rv32_pkg::*;

  word_t      alu_b;
  word_t      alu_out;
  word_t      addr_sum;  // rs1 + imm, for loads, stores and JALR
  word_t      pc_rel;    // pc + imm, for branches, JAL and AUIPC
  word_t      pc_plus4;
  logic [4:0] shamt;
  logic       taken;

  assign alu_b = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = alu_b[4:0];

  always_comb begin
    case (dec.alu_op)
      alu_sub:    alu_out = rs1_data - alu_b;
      alu_sll:    alu_out = rs1_data << shamt;
      alu_slt:    alu_out = {31'b0, $signed(rs1_data) < $signed(alu_b)};
      alu_sltu:   alu_out = {31'b0, rs1_data < alu_b};
      alu_xor:    alu_out = rs1_data ^ alu_b;
      alu_srl:    alu_out = rs1_data >> shamt;
      alu_sra:    alu_out = word_t'($signed(rs1_data) >>> shamt);
      alu_or:     alu_out = rs1_data | alu_b;
      alu_and:    alu_out = rs1_data & alu_b;
      alu_pass_b: alu_out = alu_b;
      default:    alu_out = rs1_data + alu_b;
    endcase
  end

  // Branch condition from funct3
  always_comb begin
    case (dec.funct3)
      3'b000:  taken = rs1_data == rs2_data;
      3'b001:  taken = rs1_data != rs2_data;
      3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);
      3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  taken = rs1_data < rs2_data;
      3'b111:  taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  assign addr_sum = rs1_data + dec.imm;
  assign pc_rel   = pc + dec.imm;
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    exe.alu_result = dec.is_auipc ? pc_rel : alu_out;
    exe.mem_addr   = addr_sum;
    exe.link_pc    = pc_plus4;

    if (dec.is_jalr) begin
      exe.next_pc = {addr_sum[31:1], 1'b0};
    end else if (dec.is_jal || (dec.is_branch && taken)) begin
      exe.next_pc = pc_rel;
    end else begin
      exe.next_pc = pc_plus4;
    end
  end

endmodule

// File: result/mem_align.sv
`timescale 1ns/1ps

module mem_align (
  input  rv32_pkg::decoded_t  dec,
  input  rv32_pkg::exec_t     exe,
  input  logic                halt,
  input  rv32_pkg::word_t     load_data,
  output rv32_pkg::dmem_req_t dmem_req,
  output logic                rf_we,
  output rv32_pkg::reg_idx_t  rf_rd,
  output rv32_pkg::word_t     rf_wdata
);
  import rv32_pkg::*;

  logic [1:0] offset;      // Byte within the addressed word
  logic       store_ok;
  logic       load_ok;
  byte_en_t   lane_en;
  word_t      lane_data;
  word_t      shifted;     // Addressed byte or half moved down to bit 0
  word_t      load_value;

  assign offset = exe.mem_addr[1:0];

  // Store data arrives as alu_result, replicated so every lane holds it
  always_comb begin
    lane_en   = '0;
    lane_data = exe.alu_result;
    store_ok  = 1'b0;
    case (dec.funct3)
      3'b000: begin  // SB
        lane_en   = 4'b0001 << offset;
        lane_data = {4{exe.alu_result[7:0]}};
        store_ok  = 1'b1;
      end
      3'b001: begin  // SH
        lane_en   = 4'b0011 << offset;
        lane_data = {2{exe.alu_result[15:0]}};
        store_ok  = !offset[0];
      end
      3'b010: begin  // SW
        lane_en  = 4'b1111;
        store_ok = offset == 2'b00;
      end
      default: ;
    endcase
  end

  assign shifted = load_data >> {offset, 3'b000};

  always_comb begin
    load_value = load_data;
    load_ok    = 1'b0;
    case (dec.funct3)
      3'b000: begin load_value = {{24{shifted[7]}}, shifted[7:0]};   load_ok = 1'b1;       end
      3'b001: begin load_value = {{16{shifted[15]}}, shifted[15:0]}; load_ok = !offset[0]; end
      3'b010: begin load_value = load_data;                          load_ok = offset == 0; end
      3'b100: begin load_value = {24'b0, shifted[7:0]};              load_ok = 1'b1;       end
      3'b101: begin load_value = {16'b0, shifted[15:0]};             load_ok = !offset[0]; end
      default: ;
    endcase
  end

  assign dmem_req.addr    = {exe.mem_addr[31:2], 2'b00};
  assign dmem_req.wdata   = lane_data;
  assign dmem_req.byte_en = (dec.is_store && store_ok && !halt) ? lane_en : '0;

  // A misaligned or undefined load drops its write-back
  assign rf_we = dec.reg_write && !halt && !(dec.is_load && !load_ok);
  assign rf_rd = dec.rd;

  always_comb begin
    if (dec.is_jal || dec.is_jalr) begin
      rf_wdata = exe.link_pc;
    end else if (dec.is_load) begin
      rf_wdata = load_value;
    end else begin
      rf_wdata = exe.alu_result;
    end
  end

endmodule

// File: verilog/rv32_core.sv
`timescale 1ns/1ps

module rv32_core #(
  parameter rv32_pkg::word_t reset_pc = '0
) (
  input  logic                clk,
  input  logic                rst,
  output rv32_pkg::word_t     pc,
  input  rv32_pkg::word_t     insn,
  output rv32_pkg::dmem_req_t dmem_req,
  input  rv32_pkg::word_t     load_data,
  output logic                halt
);
  import rv32_pkg::*;

  decoded_t dec;
  exec_t    exe;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     rf_we;
  reg_idx_t rf_rd;
  word_t    rf_wdata;

  fetch_unit #(
    .reset_pc (reset_pc)
  ) fetch_unit_inst (
    .clk  (clk),
    .rst  (rst),
    .dec  (dec),
    .exe  (exe),
    .pc   (pc),
    .halt (halt)
  );

  insn_decoder insn_decoder_inst (
    .insn (insn),
    .dec  (dec)
  );

  reg_file reg_file_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .rd       (rf_rd),
    .wdata    (rf_wdata)
  );

  execute_unit execute_unit_inst (
    .dec      (dec),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .exe      (exe)
  );

  mem_align mem_align_inst (
    .dec       (dec),
    .exe       (exe),
    .halt      (halt),
    .load_data (load_data),
    .dmem_req  (dmem_req),
    .rf_we     (rf_we),
    .rf_rd     (rf_rd),
    .rf_wdata  (rf_wdata)
  );

endmodule

// File: test/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Base instruction formats
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

task automatic emit(input logic [31:0] w);
  imem[n_insn] = w;
  n_insn++;
endtask

// LUI plus ADDI, upper part rounded for the sign of the low twelve bits
task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
  logic [31:0] upper;
  upper = (v + 32'h800) >> 12;
  emit(enc_u(upper[19:0], rd, 7'b0110111));
  emit(enc_i(v[11:0], rd, 3'b000, rd, 7'b0010011));
endtask

task automatic expect_store(input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] data, input int grp);
  exp_addr[exp_count]  = addr;
  exp_be[exp_count]    = be;
  exp_data[exp_count]  = data;
  exp_group[exp_count] = grp;
  exp_count++;
endtask

// SW to the next free slot above x31; live = 0 marks a store that must not happen
task automatic sw_check(input logic [4:0] rs2, input logic [31:0] value, input int grp,
                        input bit live);
  emit(enc_s(st_off[11:0], rs2, 5'd31, 3'b010));
  if (live) begin
    expect_store(32'h400 + st_off, 4'hf, value, grp);
  end
  st_off += 4;
endtask

`endif

// File: test/tb_rv32_core.sv
`timescale 1ns/1ps

module tb_rv32_core;
  import rv32_pkg::*;

  localparam logic [31:0] load_word = 32'hC3E1_7F8A;  // Mixed sign bytes and halves

  logic        clk = 1'b0;
  logic        rst;
  word_t       pc;
  word_t       insn;
  dmem_req_t   dmem_req;
  word_t       load_data;
  logic        halt;
  logic [31:0] imem [0:511];
  logic [31:0] dmem [0:511];
  logic [31:0] exp_addr [0:255];
  logic [3:0]  exp_be [0:255];
  logic [31:0] exp_data [0:255];
  int          exp_group [0:255];
  int          exp_count = 0;
  int          exp_idx = 0;
  int          n_insn = 0;
  int          st_off = 0;
  int          errors = 0;
  string       group_name [0:5] = '{"alu", "branch", "jump", "subword store", "load", "x0"};
  logic [31:0] cur_addr;
  logic [3:0]  cur_be;
  logic [31:0] cur_data;
  logic        store;

  `include "tb_program.svh"

  always #5 clk = ~clk;

  rv32_core #(.reset_pc(32'h0)) rv32_core_inst (
    .clk       (clk),
    .rst       (rst),
    .pc        (pc),
    .insn      (insn),
    .dmem_req  (dmem_req),
    .load_data (load_data),
    .halt      (halt)
  );

  // Memory models, reads see the contents from before this cycle's write
  assign insn      = imem[pc[10:2]];
  assign load_data = dmem[dmem_req.addr[10:2]];

  always @(posedge clk) begin
    for (int k = 0; k < 4; k++) begin
      if (dmem_req.byte_en[k]) dmem[dmem_req.addr[10:2]][8*k +: 8] <= dmem_req.wdata[8*k +: 8];
    end
  end

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input bit alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  task automatic build_program();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v;
    logic [31:0] p;
    logic [31:0] lane;
    logic [2:0]  f3s [0:5];
    logic [4:0]  sh;
    int          k;
    f3s = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
    emit(enc_i(12'h400, 5'd0, 3'b000, 5'd31, 7'b0010011));  // Store base
    emit(enc_i(12'h300, 5'd0, 3'b000, 5'd30, 7'b0010011));  // Load base
    a = $urandom;
    b = $urandom;
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int i = 0; i < 10; i++) begin
      emit(enc_r(i >= 8 ? 7'h20 : 7'h00, 5'd2, 5'd1, i == 9 ? 3'd5 : 3'(i % 8), 5'd3));
      sw_check(5'd3, alu_ref(i == 9 ? 3'd5 : 3'(i % 8), i >= 8, a, b), 0, 1);
    end
    for (int i = 0; i < 6; i++) begin
      v = $urandom;
      emit(enc_i(v[11:0], 5'd1, f3s[i], 5'd3, 7'b0010011));
      sw_check(5'd3, alu_ref(f3s[i], 0, a, {{20{v[11]}}, v[11:0]}), 0, 1);
    end
    sh = 5'($urandom);
    emit(enc_i({7'h00, sh}, 5'd1, 3'd1, 5'd3, 7'b0010011));
    sw_check(5'd3, a << sh, 0, 1);
    emit(enc_i({7'h00, sh}, 5'd1, 3'd5, 5'd3, 7'b0010011));
    sw_check(5'd3, a >> sh, 0, 1);
    emit(enc_i({7'h20, sh}, 5'd1, 3'd5, 5'd3, 7'b0010011));
    sw_check(5'd3, 32'($signed(a) >>> sh), 0, 1);
    v = $urandom;
    emit(enc_u(v[19:0], 5'd3, 7'b0110111));
    sw_check(5'd3, {v[19:0], 12'b0}, 0, 1);
    p = n_insn * 4;
    emit(enc_u(v[19:0], 5'd3, 7'b0010111));
    sw_check(5'd3, p + {v[19:0], 12'b0}, 0, 1);

    // Each branch skips a fall-through marker store when taken
    load_const(5'd1, 32'hFFFF_FFFB);
    emit(enc_i(12'd3, 5'd0, 3'b000, 5'd2, 7'b0010011));
    k = 0;
    foreach (f3s[i]) begin
      p = {29'b0, i == 0 ? 3'd0 : i == 1 ? 3'd1 : 3'(i + 2)};
      for (int j = 0; j < 3; j++) begin
        a = (j == 1) ? 32'd3 : 32'hFFFF_FFFB;
        b = (j == 0) ? 32'd3 : 32'hFFFF_FFFB;
        emit(enc_b(13'd12, j == 0 ? 5'd2 : 5'd1, j == 1 ? 5'd2 : 5'd1, p[2:0]));
        emit(enc_i(12'(100 + 2 * k), 5'd0, 3'b000, 5'd3, 7'b0010011));
        sw_check(5'd3, 100 + 2 * k, 1, !branch_ref(p[2:0], a, b));
        emit(enc_i(12'(101 + 2 * k), 5'd0, 3'b000, 5'd3, 7'b0010011));
        sw_check(5'd3, 101 + 2 * k, 1, 1);
        k++;
      end
    end

    p = n_insn * 4;
    emit(enc_j(21'd12, 5'd5));
    emit(enc_i(12'd7, 5'd0, 3'b000, 5'd3, 7'b0010011));
    sw_check(5'd3, 7, 2, 0);
    sw_check(5'd5, p + 4, 2, 1);
    p = n_insn * 4;
    emit(enc_i(12'(p + 17), 5'd0, 3'b000, 5'd6, 7'b0010011));  // Odd target, bit 0 dropped
    emit(enc_i(12'd0, 5'd6, 3'b000, 5'd7, 7'b1100111));
    emit(enc_i(12'd9, 5'd0, 3'b000, 5'd3, 7'b0010011));
    sw_check(5'd3, 9, 2, 0);
    sw_check(5'd7, p + 8, 2, 1);

    v = $urandom;
    load_const(5'd3, v);
    for (int i = 0; i < 4; i++) begin
      emit(enc_s(12'(st_off + i), 5'd3, 5'd31, 3'b000));
      expect_store(32'h400 + st_off, 4'b0001 << i, {4{v[7:0]}}, 3);
      st_off += 4;
    end
    for (int i = 0; i < 4; i += 2) begin
      emit(enc_s(12'(st_off + i), 5'd3, 5'd31, 3'b001));
      expect_store(32'h400 + st_off, 4'b0011 << i, {2{v[15:0]}}, 3);
      st_off += 4;
    end
    emit(enc_s(12'(st_off + 1), 5'd3, 5'd31, 3'b001));  // Misaligned SH, no store cycle
    st_off += 4;
    sw_check(5'd3, v, 3, 1);

    for (int i = 0; i < 4; i++) begin
      lane = load_word >> (8 * i);
      emit(enc_i(12'(i), 5'd30, 3'd0, 5'd4, 7'b0000011));
      sw_check(5'd4, {{24{lane[7]}}, lane[7:0]}, 4, 1);
      emit(enc_i(12'(i), 5'd30, 3'd4, 5'd4, 7'b0000011));
      sw_check(5'd4, {24'b0, lane[7:0]}, 4, 1);
      if (i % 2 == 0) begin
        emit(enc_i(12'(i), 5'd30, 3'd1, 5'd4, 7'b0000011));
        sw_check(5'd4, {{16{lane[15]}}, lane[15:0]}, 4, 1);
        emit(enc_i(12'(i), 5'd30, 3'd5, 5'd4, 7'b0000011));
        sw_check(5'd4, {16'b0, lane[15:0]}, 4, 1);
      end
    end
    emit(enc_i(12'd0, 5'd30, 3'd2, 5'd4, 7'b0000011));
    sw_check(5'd4, load_word, 4, 1);
    emit(enc_i(12'd55, 5'd0, 3'b000, 5'd4, 7'b0010011));
    emit(enc_i(12'd1, 5'd30, 3'd1, 5'd4, 7'b0000011));  // Misaligned LH keeps x4
    sw_check(5'd4, 55, 4, 1);

    emit(enc_i(12'd123, 5'd0, 3'b000, 5'd0, 7'b0010011));
    sw_check(5'd0, 0, 5, 1);
    emit(32'h0000_0073);  // ECALL
    sw_check(5'd3, 0, 5, 0);
  endtask

  assign store    = dmem_req.byte_en != '0;
  assign cur_addr = exp_addr[exp_idx];
  assign cur_be   = exp_be[exp_idx];
  assign cur_data = exp_data[exp_idx];

  store_in_list: assert property (@(posedge clk) disable iff (rst) store |-> exp_idx < exp_count)
    else begin
      $display("unexpected store cycle at %0t to %h", $time, $sampled(dmem_req.addr));
      errors++;
    end
  addr_ok: assert property (@(posedge clk) disable iff (rst)
    store && exp_idx < exp_count |-> dmem_req.addr == cur_addr)
    else begin
      $display("mismatch %0t dmem_req.addr got %h expected %h", $time,
               $sampled(dmem_req.addr), $sampled(cur_addr));
      errors++;
    end
  be_ok: assert property (@(posedge clk) disable iff (rst)
    store && exp_idx < exp_count |-> dmem_req.byte_en == cur_be)
    else begin
      $display("mismatch %0t dmem_req.byte_en got %h expected %h", $time,
               $sampled(dmem_req.byte_en), $sampled(cur_be));
      errors++;
    end
  data_ok: assert property (@(posedge clk) disable iff (rst)
    store && exp_idx < exp_count |-> ((dmem_req.wdata ^ cur_data) & lane_mask(cur_be)) == '0)
    else begin
      $display("mismatch %0t dmem_req.wdata got %h expected %h", $time,
               $sampled(dmem_req.wdata), $sampled(cur_data));
      errors++;
    end
  pc_held: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(pc))
    else begin
      $display("pc moved while halted at %0t", $time);
      errors++;
    end

  // Step through the list, one report line when a group's last store passes
  always @(posedge clk) begin
    if (!rst && store && exp_idx < exp_count) begin
      exp_idx <= exp_idx + 1;
      if (exp_idx + 1 == exp_count || exp_group[exp_idx + 1] != exp_group[exp_idx])
        $display("%s: done, %0d errors so far", group_name[exp_group[exp_idx]], errors);
    end
  end

  initial begin
    rst = 1'b1;
    void'($urandom(6951));
    for (int i = 0; i < 512; i++) begin
      imem[i] = 32'h0000_0013;
      dmem[i] = {i[15:0], ~i[15:0]};
    end
    dmem[32'h300 >> 2] = load_word;
    build_program();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    wait (halt === 1'b1);
    repeat (8) @(posedge clk);
    $display("halt: pc held at %h", pc);
    if (exp_idx != exp_count) begin
      $display("only %0d of %0d expected stores were seen", exp_idx, exp_count);
      errors++;
    end
    $display("summary: %0d stores checked, %0d errors", exp_idx, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog, one cycle per instruction plus reset and drain margin
  initial begin
    #1;
    #(n_insn * 10 + 500);
    $display("timeout: core did not halt in time");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: rv32_core.f
+incdir+test
common/rv32_pkg.sv
verilog/fetch_unit.sv
decode/insn_decoder.sv
verilog/reg_file.sv
execute/execute_unit.sv
result/mem_align.sv
verilog/rv32_core.sv
test/tb_rv32_core.sv

// File: Makefile
TOP = tb_rv32_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f rv32_core.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log; then exit 1; fi
	@grep -q "NO ERRORS" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f rv32_core.f

clean:
	rm -rf obj_dir sim.log
